//--- iq_cfg_pkg.sv
package iq_cfg_pkg;

	// Rename side.
	localparam int DISPATCH_WIDTH = 4; // Micro-op lanes per cycle.
	localparam int RANK_W = $clog2(DISPATCH_WIDTH); // Rank of a lane among valid lanes.

	// Queue storage.
	localparam int IQ_DEPTH = 16; // Entries.
	localparam int IQ_IDX_W = $clog2(IQ_DEPTH); // Entry index width.
	localparam int FREE_CNT_W = IQ_IDX_W + 1; // Holds 0 to IQ_DEPTH.

	// Function unit side.
	localparam int FU_CREDITS = 4; // Granted after reset.
	localparam int CREDIT_W = $clog2(FU_CREDITS + 1); // Holds 0 to FU_CREDITS.

endpackage

//--- iq_uop_pkg.sv
package iq_uop_pkg;

	import iq_cfg_pkg::*;

	localparam int PREG_W = 6; // Physical register tag.
	localparam int OPC_W = 5; // Opcode.

	typedef logic [PREG_W-1:0] preg_t;
	typedef logic [OPC_W-1:0] opc_t;

	// Queue slot number.
	typedef logic [IQ_IDX_W-1:0] iq_idx_t;

endpackage

//--- iq_select_lib.sv
`timescale 1ns/100ps

// Lowest set bit wins. N is a power of two, at least 2.
module iq_prio_lsb #(
	parameter int N = 16,
	localparam int W = (N > 1) ? $clog2(N) : 1
) (
	input  logic [N-1:0] req_i,
	output logic [W-1:0] idx_o,
	output logic         any_o
);

	if (N == 2) begin : g_pair
		assign idx_o = ~req_i[0]; // Bit 0 has priority.
		assign any_o = |req_i;
	end else begin : g_split
		localparam int H = N / 2;

		logic [W-2:0] idx_lo;
		logic [W-2:0] idx_hi;
		logic         any_lo;
		logic         any_hi;

		iq_prio_lsb #(.N(H)) u_lo (
			.req_i (req_i[H-1:0]),
			.idx_o (idx_lo),
			.any_o (any_lo)
		);

		iq_prio_lsb #(.N(H)) u_hi (
			.req_i (req_i[N-1:H]),
			.idx_o (idx_hi),
			.any_o (any_hi)
		);

		assign any_o = any_lo | any_hi;
		assign idx_o = any_lo ? {1'b0, idx_lo} : {1'b1, idx_hi}; // Low half first.
	end

endmodule

// Number of enables strictly below each position.
module iq_prefix_count #(
	parameter int N = 4,
	localparam int CW = (N > 1) ? $clog2(N) : 1
) (
	input  logic [N-1:0]         en_i,
	output logic [N-1:0][CW-1:0] cnt_o
);

	logic [CW-1:0] acc;

	always_comb begin
		acc = '0;
		for (int i = 0; i < N; i++) begin
			cnt_o[i] = acc;
			acc = acc + CW'(en_i[i]); // Wraps only after the last position.
		end
	end

endmodule

// Ones at every position below idx_i. N is a power of two, at least 2.
module iq_below_mask #(
	parameter int N = 16,
	localparam int W = (N > 1) ? $clog2(N) : 1
) (
	input  logic [W-1:0] idx_i,
	output logic [N-1:0] mask_o
);

	if (N == 2) begin : g_pair
		assign mask_o[0] = idx_i[0];
		assign mask_o[1] = 1'b0;
	end else begin : g_split
		localparam int H = N / 2;

		logic [H-1:0] low;

		iq_below_mask #(.N(H)) u_low (
			.idx_i  (idx_i[W-2:0]),
			.mask_o (low)
		);

		// Upper index bit fills the low half and enables the high half.
		assign mask_o[N-1:H] = low & {H{idx_i[W-1]}};
		assign mask_o[H-1:0] = low | {H{idx_i[W-1]}};
	end

endmodule

//--- iq_dispatch.sv
`timescale 1ns/100ps

module iq_dispatch
	import iq_cfg_pkg::*;
	import iq_uop_pkg::*;
(
	input  logic [DISPATCH_WIDTH-1:0]          disp_valid_i,
	input  logic [IQ_DEPTH-1:0]                free_mask_i,
	output logic                               disp_ready_o,
	output logic [DISPATCH_WIDTH-1:0]          wr_en_o,
	output iq_idx_t [DISPATCH_WIDTH-1:0]       wr_idx_o
);

	logic [DISPATCH_WIDTH-1:0][RANK_W-1:0] rank;
	logic [FREE_CNT_W-1:0]                 free_cnt;
	logic [DISPATCH_WIDTH-1:0]             lane_ok;

	iq_prefix_count #(.N(DISPATCH_WIDTH)) u_rank (
		.en_i  (disp_valid_i),
		.cnt_o (rank)
	);

	always_comb begin
		free_cnt = '0;
		for (int i = 0; i < IQ_DEPTH; i++) begin
			free_cnt = free_cnt + FREE_CNT_W'(free_mask_i[i]);
		end
	end

	for (genvar k = 0; k < DISPATCH_WIDTH; k++) begin : g_lane
		logic                base_any;
		iq_idx_t             base_idx;
		logic [IQ_DEPTH-1:0] below;
		logic [IQ_DEPTH-1:0] avail;
		iq_idx_t             pick_idx;
		logic                pick_any;

		// Last entry claimed by an earlier valid lane.
		if (k == 0) begin : g_first
			assign base_any = 1'b0;
			assign base_idx = '0;
		end else begin : g_next
			assign base_any = disp_valid_i[k-1] | g_lane[k-1].base_any;
			assign base_idx = disp_valid_i[k-1] ? g_lane[k-1].pick_idx : g_lane[k-1].base_idx;
		end

		iq_below_mask #(.N(IQ_DEPTH)) u_below (
			.idx_i  (base_idx),
			.mask_o (below)
		);

		assign avail = free_mask_i & ~below
			& ~({IQ_DEPTH{base_any}} & (IQ_DEPTH'(1) << base_idx)); // Skip claimed.

		iq_prio_lsb #(.N(IQ_DEPTH)) u_pick (
			.req_i (avail),
			.idx_o (pick_idx),
			.any_o (pick_any)
		);

		// Lane k needs rank+1 free entries.
		assign lane_ok[k] = ~disp_valid_i[k]
			| (pick_any & (free_cnt > FREE_CNT_W'(rank[k])));
		assign wr_en_o[k] = disp_valid_i[k] & disp_ready_o;
		assign wr_idx_o[k] = pick_idx;
	end

	assign disp_ready_o = &lane_ok; // All or none.

endmodule

//--- iq_entries.sv
`timescale 1ns/100ps

module iq_entries
	import iq_cfg_pkg::*;
	import iq_uop_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst_n_i,
	input  opc_t [DISPATCH_WIDTH-1:0]    wr_opc_i,
	input  preg_t [DISPATCH_WIDTH-1:0]   wr_dst_i,
	input  preg_t [DISPATCH_WIDTH-1:0]   wr_src1_i,
	input  logic [DISPATCH_WIDTH-1:0]    wr_src1_rdy_i,
	input  preg_t [DISPATCH_WIDTH-1:0]   wr_src2_i,
	input  logic [DISPATCH_WIDTH-1:0]    wr_src2_rdy_i,
	input  logic [DISPATCH_WIDTH-1:0]    wr_en_i,
	input  iq_idx_t [DISPATCH_WIDTH-1:0] wr_idx_i,
	input  logic                         wake_valid_i,
	input  preg_t                        wake_tag_i,
	input  logic                         sel_take_i,
	output logic [IQ_DEPTH-1:0]          free_mask_o,
	output logic                         sel_valid_o,
	output opc_t                         sel_opc_o,
	output preg_t                        sel_dst_o,
	output preg_t                        sel_src1_o,
	output preg_t                        sel_src2_o
);

	logic [IQ_DEPTH-1:0]       valid_q;
	logic [IQ_DEPTH-1:0]       rdy1_q;
	logic [IQ_DEPTH-1:0]       rdy2_q;
	opc_t                      opc_q [IQ_DEPTH];
	preg_t                     dst_q [IQ_DEPTH];
	preg_t                     src1_q [IQ_DEPTH];
	preg_t                     src2_q [IQ_DEPTH];
	logic [IQ_DEPTH-1:0]       hit1;
	logic [IQ_DEPTH-1:0]       hit2;
	logic [DISPATCH_WIDTH-1:0] lane_rdy1;
	logic [DISPATCH_WIDTH-1:0] lane_rdy2;
	logic [IQ_DEPTH-1:0]       req;
	iq_idx_t                   sel_idx;

	// Broadcast against stored sources.
	always_comb begin
		for (int i = 0; i < IQ_DEPTH; i++) begin
			hit1[i] = wake_valid_i & valid_q[i] & (src1_q[i] == wake_tag_i);
			hit2[i] = wake_valid_i & valid_q[i] & (src2_q[i] == wake_tag_i);
		end
	end

	// Incoming lanes see the same broadcast.
	always_comb begin
		for (int k = 0; k < DISPATCH_WIDTH; k++) begin
			lane_rdy1[k] = wr_src1_rdy_i[k] | (wake_valid_i & (wr_src1_i[k] == wake_tag_i));
			lane_rdy2[k] = wr_src2_rdy_i[k] | (wake_valid_i & (wr_src2_i[k] == wake_tag_i));
		end
	end

	assign req = valid_q & rdy1_q & rdy2_q;

	iq_prio_lsb #(.N(IQ_DEPTH)) u_select (
		.req_i (req),
		.idx_o (sel_idx),
		.any_o (sel_valid_o)
	);

	assign sel_opc_o = opc_q[sel_idx];
	assign sel_dst_o = dst_q[sel_idx];
	assign sel_src1_o = src1_q[sel_idx];
	assign sel_src2_o = src2_q[sel_idx];
	assign free_mask_o = ~valid_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;
			rdy1_q <= '0;
			rdy2_q <= '0;
		end else begin
			rdy1_q <= rdy1_q | hit1;
			rdy2_q <= rdy2_q | hit2;
			if (sel_take_i) begin
				valid_q[sel_idx] <= 1'b0;
			end
			// Writes only hit free entries, so they never meet the take.
			for (int k = 0; k < DISPATCH_WIDTH; k++) begin
				if (wr_en_i[k]) begin
					valid_q[wr_idx_i[k]] <= 1'b1;
					rdy1_q[wr_idx_i[k]] <= lane_rdy1[k];
					rdy2_q[wr_idx_i[k]] <= lane_rdy2[k];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < DISPATCH_WIDTH; k++) begin
			if (wr_en_i[k]) begin
				opc_q[wr_idx_i[k]] <= wr_opc_i[k];
				dst_q[wr_idx_i[k]] <= wr_dst_i[k];
				src1_q[wr_idx_i[k]] <= wr_src1_i[k];
				src2_q[wr_idx_i[k]] <= wr_src2_i[k];
			end
		end
	end

endmodule

//--- iq_issue_port.sv
`timescale 1ns/100ps

module iq_issue_port
	import iq_cfg_pkg::*;
	import iq_uop_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n_i,
	input  logic  sel_valid_i,
	input  opc_t  sel_opc_i,
	input  preg_t sel_dst_i,
	input  preg_t sel_src1_i,
	input  preg_t sel_src2_i,
	input  logic  fu_credit_i,
	output logic  sel_take_o,
	output logic  issue_valid_o,
	output opc_t  issue_opc_o,
	output preg_t issue_dst_o,
	output preg_t issue_src1_o,
	output preg_t issue_src2_o
);

	logic [CREDIT_W-1:0] credit_q;

	assign sel_take_o = sel_valid_i & (credit_q != '0);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			credit_q <= CREDIT_W'(FU_CREDITS);
			issue_valid_o <= 1'b0;
		end else begin
			issue_valid_o <= sel_take_o; // One pulse per take.
			case ({sel_take_o, fu_credit_i})
				2'b10: credit_q <= credit_q - CREDIT_W'(1);
				2'b01: credit_q <= credit_q + CREDIT_W'(1);
				default: credit_q <= credit_q; // Take and return cancel.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (sel_take_o) begin
			issue_opc_o <= sel_opc_i;
			issue_dst_o <= sel_dst_i;
			issue_src1_o <= sel_src1_i;
			issue_src2_o <= sel_src2_i;
		end
	end

endmodule

//--- iq_top.sv
`timescale 1ns/100ps

module iq_top
	import iq_cfg_pkg::*;
	import iq_uop_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  logic [DISPATCH_WIDTH-1:0]   disp_valid_i,
	input  opc_t [DISPATCH_WIDTH-1:0]   disp_opc_i,
	input  preg_t [DISPATCH_WIDTH-1:0]  disp_dst_i,
	input  preg_t [DISPATCH_WIDTH-1:0]  disp_src1_i,
	input  logic [DISPATCH_WIDTH-1:0]   disp_src1_rdy_i,
	input  preg_t [DISPATCH_WIDTH-1:0]  disp_src2_i,
	input  logic [DISPATCH_WIDTH-1:0]   disp_src2_rdy_i,
	output logic                        disp_ready_o,
	input  logic                        wake_valid_i,
	input  preg_t                       wake_tag_i,
	input  logic                        fu_credit_i,
	output logic                        issue_valid_o,
	output opc_t                        issue_opc_o,
	output preg_t                       issue_dst_o,
	output preg_t                       issue_src1_o,
	output preg_t                       issue_src2_o
);

	logic [DISPATCH_WIDTH-1:0]    wr_en;
	iq_idx_t [DISPATCH_WIDTH-1:0] wr_idx;
	logic [IQ_DEPTH-1:0]          free_mask;
	logic                         sel_valid;
	opc_t                         sel_opc;
	preg_t                        sel_dst;
	preg_t                        sel_src1;
	preg_t                        sel_src2;
	logic                         sel_take;

	iq_dispatch u_dispatch (
		.disp_valid_i (disp_valid_i),
		.free_mask_i  (free_mask),
		.disp_ready_o (disp_ready_o),
		.wr_en_o      (wr_en),
		.wr_idx_o     (wr_idx)
	);

	iq_entries u_entries (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.wr_opc_i      (disp_opc_i),
		.wr_dst_i      (disp_dst_i),
		.wr_src1_i     (disp_src1_i),
		.wr_src1_rdy_i (disp_src1_rdy_i),
		.wr_src2_i     (disp_src2_i),
		.wr_src2_rdy_i (disp_src2_rdy_i),
		.wr_en_i       (wr_en),
		.wr_idx_i      (wr_idx),
		.wake_valid_i  (wake_valid_i),
		.wake_tag_i    (wake_tag_i),
		.sel_take_i    (sel_take),
		.free_mask_o   (free_mask),
		.sel_valid_o   (sel_valid),
		.sel_opc_o     (sel_opc),
		.sel_dst_o     (sel_dst),
		.sel_src1_o    (sel_src1),
		.sel_src2_o    (sel_src2)
	);

	iq_issue_port u_issue (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.sel_valid_i   (sel_valid),
		.sel_opc_i     (sel_opc),
		.sel_dst_i     (sel_dst),
		.sel_src1_i    (sel_src1),
		.sel_src2_i    (sel_src2),
		.fu_credit_i   (fu_credit_i),
		.sel_take_o    (sel_take),
		.issue_valid_o (issue_valid_o),
		.issue_opc_o   (issue_opc_o),
		.issue_dst_o   (issue_dst_o),
		.issue_src1_o  (issue_src1_o),
		.issue_src2_o  (issue_src2_o)
	);

endmodule

//--- tb_iq_top.sv
`timescale 1ns/100ps

module tb_iq_top
	import iq_cfg_pkg::*;
	import iq_uop_pkg::*;
();

	localparam logic [31:0] LFSR_SEED = 32'h2846_c932;
	localparam int RANDOM_ROWS = 40;

	typedef struct packed {
		logic [DISPATCH_WIDTH-1:0]  valid;
		opc_t [DISPATCH_WIDTH-1:0]  opc;
		preg_t [DISPATCH_WIDTH-1:0] dst;
		preg_t [DISPATCH_WIDTH-1:0] src1;
		logic [DISPATCH_WIDTH-1:0]  rdy1;
		preg_t [DISPATCH_WIDTH-1:0] src2;
		logic [DISPATCH_WIDTH-1:0]  rdy2;
		logic                       wake_v;
		preg_t                      wake_tag;
		logic                       credit;
		logic                       chk; // Row carries a directed issue destination.
		preg_t                      exp_dst;
	} row_t;

	logic clk;
	logic rst_n;
	logic [DISPATCH_WIDTH-1:0] disp_valid;
	opc_t [DISPATCH_WIDTH-1:0] disp_opc;
	preg_t [DISPATCH_WIDTH-1:0] disp_dst;
	preg_t [DISPATCH_WIDTH-1:0] disp_src1;
	logic [DISPATCH_WIDTH-1:0] disp_src1_rdy;
	preg_t [DISPATCH_WIDTH-1:0] disp_src2;
	logic [DISPATCH_WIDTH-1:0] disp_src2_rdy;
	logic disp_ready;
	logic wake_valid;
	preg_t wake_tag;
	logic fu_credit;
	logic issue_valid;
	opc_t issue_opc;
	preg_t issue_dst;
	preg_t issue_src1;
	preg_t issue_src2;

	// Reference model of the queue.
	logic [IQ_DEPTH-1:0] m_valid;
	logic [IQ_DEPTH-1:0] m_rdy1;
	logic [IQ_DEPTH-1:0] m_rdy2;
	opc_t m_opc [IQ_DEPTH];
	preg_t m_dst [IQ_DEPTH];
	preg_t m_src1 [IQ_DEPTH];
	preg_t m_src2 [IQ_DEPTH];
	int m_credit;
	logic e_valid; // Expected issue register.
	opc_t e_opc;
	preg_t e_dst;
	preg_t e_src1;
	preg_t e_src2;

	row_t rows [$];
	string names [$];
	row_t stage;
	logic [31:0] lfsr_q;
	logic table_ready;
	int errors;
	int test_errors;
	int tests_run;
	int tests_pass;

	iq_top dut (
		.clk             (clk),
		.rst_n_i         (rst_n),
		.disp_valid_i    (disp_valid),
		.disp_opc_i      (disp_opc),
		.disp_dst_i      (disp_dst),
		.disp_src1_i     (disp_src1),
		.disp_src1_rdy_i (disp_src1_rdy),
		.disp_src2_i     (disp_src2),
		.disp_src2_rdy_i (disp_src2_rdy),
		.disp_ready_o    (disp_ready),
		.wake_valid_i    (wake_valid),
		.wake_tag_i      (wake_tag),
		.fu_credit_i     (fu_credit),
		.issue_valid_o   (issue_valid),
		.issue_opc_o     (issue_opc),
		.issue_dst_o     (issue_dst),
		.issue_src1_o    (issue_src1),
		.issue_src2_o    (issue_src2)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Taps 32, 22, 2, 1.
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		return fb;
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_bit());
		end
		return v;
	endfunction

	task automatic lane(input int k, input int opc, input int dst, input int s1, input int r1,
			input int s2, input int r2);
		stage.valid[k] = 1'b1;
		stage.opc[k] = opc_t'(opc);
		stage.dst[k] = preg_t'(dst);
		stage.src1[k] = preg_t'(s1);
		stage.rdy1[k] = (r1 != 0);
		stage.src2[k] = preg_t'(s2);
		stage.rdy2[k] = (r2 != 0);
	endtask

	task automatic ready_lane(input int k, input int dst);
		lane(k, dst ^ 5, dst, 1, 1, 2, 1);
	endtask

	// A negative wake or exp leaves that part of the row unused.
	task automatic push(input string name, input int wake, input int cr, input int exp);
		stage.wake_v = (wake >= 0);
		stage.wake_tag = preg_t'(wake >= 0 ? wake : 0);
		stage.credit = (cr != 0);
		stage.chk = (exp >= 0);
		stage.exp_dst = preg_t'(exp >= 0 ? exp : 0);
		rows.push_back(stage);
		names.push_back(name);
		stage = '0;
	endtask

	task automatic build_table();
		stage = '0;
		for (int k = 0; k < DISPATCH_WIDTH; k++) ready_lane(k, 10 + k);
		push("burst", -1, 0, -1);
		push("burst", -1, 0, -1); // Nothing issued before the first take.
		push("burst", -1, 1, 10);
		push("burst", -1, 1, 11);
		push("burst", -1, 1, 12);
		push("burst", -1, 1, 13);

		lane(0, 1, 20, 5, 0, 6, 1);
		lane(1, 2, 21, 7, 0, 7, 0);
		push("wakeup", 7, 0, -1); // Wakes lane 1 as it is written.
		push("wakeup", -1, 0, -1);
		push("wakeup", 5, 0, 21);
		push("wakeup", -1, 0, -1);
		push("wakeup", -1, 1, 20);
		push("wakeup", -1, 1, -1);

		lane(0, 3, 30, 9, 0, 1, 1);
		ready_lane(1, 31);
		lane(2, 4, 32, 10, 0, 1, 1);
		ready_lane(3, 33);
		push("lowest_idx", -1, 0, -1);
		push("lowest_idx", -1, 0, -1);
		push("lowest_idx", -1, 0, 31);
		ready_lane(0, 34); // Refills entries 1 and 3.
		ready_lane(1, 35);
		push("lowest_idx", 9, 0, 33);
		push("lowest_idx", -1, 1, -1);
		push("lowest_idx", -1, 1, 30);
		push("lowest_idx", 10, 1, 34);
		push("lowest_idx", -1, 1, 35);
		push("lowest_idx", -1, 1, 32);
		push("lowest_idx", -1, 1, -1);

		for (int k = 0; k < DISPATCH_WIDTH; k++) ready_lane(k, 40 + k);
		push("credits", -1, 0, -1);
		ready_lane(0, 44);
		ready_lane(1, 45);
		push("credits", -1, 0, -1);
		push("credits", -1, 0, 40);
		push("credits", -1, 0, 41);
		push("credits", -1, 0, 42);
		push("credits", -1, 0, 43);
		push("credits", -1, 1, -1); // Out of credits here.
		push("credits", -1, 0, -1);
		push("credits", -1, 1, 44);
		push("credits", -1, 0, -1);
		push("credits", -1, 1, 45);
		for (int n = 0; n < 3; n++) push("credits", -1, 1, -1);

		for (int g = 0; g < 4; g++) begin
			for (int k = 0; k < DISPATCH_WIDTH; k++) lane(k, 6, 1 + 4 * g + k, 50, 0, 1, 1);
			push("full_queue", -1, 0, -1);
		end
		for (int n = 0; n < 7; n++) begin
			for (int k = 0; k < DISPATCH_WIDTH; k++) ready_lane(k, 60 + k);
			push("full_queue", n == 1 ? 50 : -1, n == 6 ? 1 : 0, n >= 3 ? n - 2 : -1);
		end
		for (int n = 0; n < 17; n++) push("full_queue", -1, 1, -1);

		for (int n = 0; n < RANDOM_ROWS; n++) begin
			for (int k = 0; k < DISPATCH_WIDTH; k++) begin
				if (rand_bits(1) != 0) begin
					lane(k, rand_bits(5), rand_bits(6), rand_bits(3), rand_bits(1),
						rand_bits(3), rand_bits(1));
				end
			end
			push("random", rand_bits(1) != 0 ? rand_bits(3) : -1, rand_bits(1), -1);
		end
	endtask

	task automatic drive(input row_t r, input logic cr);
		disp_valid = r.valid;
		disp_opc = r.opc;
		disp_dst = r.dst;
		disp_src1 = r.src1;
		disp_src1_rdy = r.rdy1;
		disp_src2 = r.src2;
		disp_src2_rdy = r.rdy2;
		wake_valid = r.wake_v;
		wake_tag = r.wake_tag;
		fu_credit = cr;
	endtask

	function automatic logic model_ready(input logic [DISPATCH_WIDTH-1:0] v);
		return (IQ_DEPTH - $countones(m_valid)) >= $countones(v);
	endfunction

	// State change of the queue at one rising edge.
	task automatic model_edge(input row_t r, input logic cr, input logic rdy);
		int sel;
		int slot;
		logic take;
		sel = -1;
		for (int i = 0; i < IQ_DEPTH; i++) begin
			if (sel < 0 && m_valid[i] && m_rdy1[i] && m_rdy2[i]) sel = i;
		end
		take = (sel >= 0) && (m_credit > 0);
		e_valid = take;
		if (take) begin
			e_opc = m_opc[sel];
			e_dst = m_dst[sel];
			e_src1 = m_src1[sel];
			e_src2 = m_src2[sel];
		end
		m_credit = m_credit + int'(cr) - int'(take);
		for (int i = 0; i < IQ_DEPTH; i++) begin
			if (r.wake_v && m_valid[i] && m_src1[i] == r.wake_tag) m_rdy1[i] = 1'b1;
			if (r.wake_v && m_valid[i] && m_src2[i] == r.wake_tag) m_rdy2[i] = 1'b1;
		end
		for (int k = 0; k < DISPATCH_WIDTH; k++) begin
			if (rdy && r.valid[k]) begin
				slot = 0;
				while (m_valid[slot]) slot++;
				m_valid[slot] = 1'b1;
				m_opc[slot] = r.opc[k];
				m_dst[slot] = r.dst[k];
				m_src1[slot] = r.src1[k];
				m_src2[slot] = r.src2[k];
				m_rdy1[slot] = r.rdy1[k] | (r.wake_v && r.src1[k] == r.wake_tag);
				m_rdy2[slot] = r.rdy2[k] | (r.wake_v && r.src2[k] == r.wake_tag);
			end
		end
		if (take) m_valid[sel] = 1'b0;
	endtask

	task automatic mismatch(input string name, input string what, input logic [31:0] exp,
			input logic [31:0] act);
		$display("Mismatch %s %s: expected %0d, actual %0d", name, what, exp, act);
		test_errors++;
	endtask

	task automatic check_row(input string name, input row_t cur, input logic exp_rdy);
		if (disp_ready !== exp_rdy) mismatch(name, "disp_ready_o", 32'(exp_rdy), 32'(disp_ready));
		if (issue_valid !== e_valid) begin
			mismatch(name, "issue_valid_o", 32'(e_valid), 32'(issue_valid));
		end else if (e_valid) begin
			if (issue_opc !== e_opc) mismatch(name, "issue_opc_o", 32'(e_opc), 32'(issue_opc));
			if (issue_dst !== e_dst) mismatch(name, "issue_dst_o", 32'(e_dst), 32'(issue_dst));
			if (issue_src1 !== e_src1) mismatch(name, "issue_src1_o", 32'(e_src1), 32'(issue_src1));
			if (issue_src2 !== e_src2) mismatch(name, "issue_src2_o", 32'(e_src2), 32'(issue_src2));
		end
		if (cur.chk) begin
			if (issue_valid !== 1'b1) begin
				$display("Error %s: no micro-op issued where destination %0d was due",
					name, cur.exp_dst);
				test_errors++;
			end else if (issue_dst !== cur.exp_dst) begin
				mismatch(name, "issue_dst_o", 32'(cur.exp_dst), 32'(issue_dst));
			end
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errors == 0) tests_pass++;
		$display("Test %s: %s, %0d errors", name, test_errors == 0 ? "passed" : "failed",
			test_errors);
		errors += test_errors;
		test_errors = 0;
	endtask

	initial begin
		row_t cur;
		logic cr;
		logic exp_rdy;
		rst_n = 1'b0;
		stage = '0;
		drive(stage, 1'b0);
		table_ready = 1'b0;
		lfsr_q = LFSR_SEED;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_pass = 0;
		m_valid = '0;
		m_rdy1 = '0;
		m_rdy2 = '0;
		m_credit = FU_CREDITS;
		e_valid = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
		for (int r = 0; r < rows.size(); r++) begin
			@(posedge clk);
			#1;
			cur = rows[r];
			cr = cur.credit && (m_credit < FU_CREDITS); // Unit returns only what it holds.
			drive(cur, cr);
			#4;
			exp_rdy = model_ready(cur.valid);
			check_row(names[r], cur, exp_rdy);
			model_edge(cur, cr, exp_rdy);
			if (r == rows.size() - 1 || names[r + 1] != names[r]) end_test(names[r]);
		end
		$display("%0d of %0d tests passed, %0d errors", tests_pass, tests_run, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		int limit;
		wait (table_ready);
		limit = rows.size() * 20;
		repeat (limit) @(posedge clk);
		$display("Timeout: the table did not finish within %0d cycles", limit);
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- filelist.f
iq_cfg_pkg.sv
iq_uop_pkg.sv
iq_select_lib.sv
iq_dispatch.sv
iq_entries.sv
iq_issue_port.sv
iq_top.sv
tb_iq_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_iq_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **' || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR)
